//--- rtl/dds_lab_pkg.sv
`default_nettype none

package dds_lab_pkg;

  // widths
  localparam int SAMPLE_W = 12;
  localparam int PHASE_W  = 32;
  localparam int SCAN_W   = 8;
  localparam int NUM_KEYS = 17;
  localparam int LFSR_W   = 5;

  typedef logic [SAMPLE_W-1:0] sample_t;     // 0 bottom of swing, 4095 top
  typedef logic [PHASE_W-1:0]  phase_t;
  typedef logic [SCAN_W-1:0]   scan_code_t;
  typedef logic [NUM_KEYS-1:0] held_keys_t;  // key 1 in the msb
  typedef logic [LFSR_W-1:0]   lfsr_t;

  typedef enum logic [1:0] {
    WAVE_SAW      = 2'd0,
    WAVE_SQUARE   = 2'd1,
    WAVE_TRIANGLE = 2'd2
  } wave_sel_e;

  typedef enum logic [1:0] {
    MOD_NONE = 2'd0,
    MOD_ASK  = 2'd1,
    MOD_BPSK = 2'd2
  } mod_sel_e;

  localparam lfsr_t LFSR_SEED = 5'd1;  // must not be zero

  //////////////////////////////////////////////////
  // make codes are ps/2 set 2, break adds bit 7
  //////////////////////////////////////////////////
  localparam scan_code_t SC_MAKE_1           = 8'h16;
  localparam scan_code_t SC_BREAK_1          = SC_MAKE_1 | 8'h80;
  localparam scan_code_t SC_MAKE_2           = 8'h1E;
  localparam scan_code_t SC_BREAK_2          = SC_MAKE_2 | 8'h80;
  localparam scan_code_t SC_MAKE_3           = 8'h26;
  localparam scan_code_t SC_BREAK_3          = SC_MAKE_3 | 8'h80;
  localparam scan_code_t SC_MAKE_4           = 8'h25;
  localparam scan_code_t SC_BREAK_4          = SC_MAKE_4 | 8'h80;
  localparam scan_code_t SC_MAKE_5           = 8'h2E;
  localparam scan_code_t SC_BREAK_5          = SC_MAKE_5 | 8'h80;
  localparam scan_code_t SC_MAKE_6           = 8'h36;
  localparam scan_code_t SC_BREAK_6          = SC_MAKE_6 | 8'h80;
  localparam scan_code_t SC_MAKE_7           = 8'h3D;
  localparam scan_code_t SC_BREAK_7          = SC_MAKE_7 | 8'h80;
  localparam scan_code_t SC_MAKE_8           = 8'h3E;
  localparam scan_code_t SC_BREAK_8          = SC_MAKE_8 | 8'h80;
  localparam scan_code_t SC_MAKE_F1          = 8'h05;
  localparam scan_code_t SC_BREAK_F1         = SC_MAKE_F1 | 8'h80;
  localparam scan_code_t SC_MAKE_F2          = 8'h06;
  localparam scan_code_t SC_BREAK_F2         = SC_MAKE_F2 | 8'h80;
  localparam scan_code_t SC_MAKE_N           = 8'h31;
  localparam scan_code_t SC_BREAK_N          = SC_MAKE_N | 8'h80;
  localparam scan_code_t SC_MAKE_M           = 8'h3A;
  localparam scan_code_t SC_BREAK_M          = SC_MAKE_M | 8'h80;
  localparam scan_code_t SC_MAKE_SPACE       = 8'h29;
  localparam scan_code_t SC_BREAK_SPACE      = SC_MAKE_SPACE | 8'h80;
  localparam scan_code_t SC_MAKE_LEFT_ARROW  = 8'h6B;
  localparam scan_code_t SC_BREAK_LEFT_ARROW = SC_MAKE_LEFT_ARROW | 8'h80;
  localparam scan_code_t SC_MAKE_RIGHT_ARROW = 8'h74;
  localparam scan_code_t SC_BREAK_RIGHT_ARROW = SC_MAKE_RIGHT_ARROW | 8'h80;
  localparam scan_code_t SC_MAKE_UP_ARROW    = 8'h75;
  localparam scan_code_t SC_BREAK_UP_ARROW   = SC_MAKE_UP_ARROW | 8'h80;
  localparam scan_code_t SC_MAKE_DOWN_ARROW  = 8'h72;
  localparam scan_code_t SC_BREAK_DOWN_ARROW = SC_MAKE_DOWN_ARROW | 8'h80;

endpackage

`default_nettype wire

//--- rtl/key_hold_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module key_hold_tracker (
  input  wire                     CLK_25MHZ,
  input  wire                     reset_from_key,
  input  wire                     key_event_ready,
  input  wire dds_lab_pkg::scan_code_t key_event_code,
  output dds_lab_pkg::held_keys_t held_keys
);

  import dds_lab_pkg::*;

  // index NUM_KEYS-1 is key 1, index 0 is the down arrow
  localparam scan_code_t MAKE_CODES [NUM_KEYS-1:0] = '{
    SC_MAKE_1,
    SC_MAKE_2,
    SC_MAKE_3,
    SC_MAKE_4,
    SC_MAKE_5,
    SC_MAKE_6,
    SC_MAKE_7,
    SC_MAKE_8,
    SC_MAKE_F1,
    SC_MAKE_F2,
    SC_MAKE_N,
    SC_MAKE_M,
    SC_MAKE_SPACE,
    SC_MAKE_LEFT_ARROW,
    SC_MAKE_RIGHT_ARROW,
    SC_MAKE_UP_ARROW,
    SC_MAKE_DOWN_ARROW
  };

  localparam scan_code_t BREAK_CODES [NUM_KEYS-1:0] = '{
    SC_BREAK_1,
    SC_BREAK_2,
    SC_BREAK_3,
    SC_BREAK_4,
    SC_BREAK_5,
    SC_BREAK_6,
    SC_BREAK_7,
    SC_BREAK_8,
    SC_BREAK_F1,
    SC_BREAK_F2,
    SC_BREAK_N,
    SC_BREAK_M,
    SC_BREAK_SPACE,
    SC_BREAK_LEFT_ARROW,
    SC_BREAK_RIGHT_ARROW,
    SC_BREAK_UP_ARROW,
    SC_BREAK_DOWN_ARROW
  };

  //////////////////////////////////////////////////
  // one flag per key, updated only on ready
  //////////////////////////////////////////////////
  always_ff @(posedge CLK_25MHZ) begin
    if (reset_from_key) begin
      held_keys <= '0;
    end else if (key_event_ready) begin
      for (int i = 0; i < NUM_KEYS; i++) begin
        if (key_event_code == MAKE_CODES[i]) begin
          held_keys[i] <= 1'b1;  // key pressed
        end else if (key_event_code == BREAK_CODES[i]) begin
          held_keys[i] <= 1'b0;  // key released
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/lfsr_stepper.sv
`timescale 1ns/1ps
`default_nettype none

module lfsr_stepper #(
  parameter int DIV_COUNT = 25000000
) (
  input  wire                CLK_25MHZ,
  input  wire                reset_from_key,
  output dds_lab_pkg::lfsr_t lfsr_state
);

  import dds_lab_pkg::*;

  localparam int CNT_W = (DIV_COUNT > 1) ? $clog2(DIV_COUNT) : 1;

  logic [CNT_W-1:0] div_cnt;
  logic             step_tick;

  assign step_tick = (div_cnt == CNT_W'(DIV_COUNT - 1));  // last cycle of the count

  // tick divider, wraps after DIV_COUNT cycles
  always_ff @(posedge CLK_25MHZ) begin
    if (reset_from_key) begin
      div_cnt <= '0;
    end else if (step_tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // x^5 + x^3 + 1, maximal length 31 states
  //////////////////////////////////////////////////
  always_ff @(posedge CLK_25MHZ) begin
    if (reset_from_key) begin
      lfsr_state <= LFSR_SEED;
    end else if (step_tick) begin
      lfsr_state <= {lfsr_state[3:0], lfsr_state[4] ^ lfsr_state[2]};
    end
  end

endmodule

`default_nettype wire

//--- rtl/dds_wave_gen.sv
`timescale 1ns/1ps
`default_nettype none

module dds_wave_gen (
  input  wire                      CLK_25MHZ,
  input  wire                      reset_from_key,
  input  wire dds_lab_pkg::phase_t phase_inc,
  input  wire dds_lab_pkg::wave_sel_e wave_sel,
  output dds_lab_pkg::sample_t     carrier_sample
);

  import dds_lab_pkg::*;

  phase_t  phase_acc;
  sample_t phase_top;
  sample_t tri_ramp;
  sample_t shaped;

  // free-running accumulator, wraps naturally
  always_ff @(posedge CLK_25MHZ) begin
    if (reset_from_key) begin
      phase_acc <= '0;
    end else begin
      phase_acc <= phase_acc + phase_inc;
    end
  end

  //////////////////////////////////////////////////
  // waveform shaping from the phase msbs
  //////////////////////////////////////////////////
  assign phase_top = phase_acc[PHASE_W-1 -: SAMPLE_W];
  assign tri_ramp  = phase_acc[PHASE_W-2 -: SAMPLE_W];  // twice the saw slope

  always_comb begin
    case (wave_sel)
      WAVE_SAW: begin
        shaped = phase_top;
      end
      WAVE_SQUARE: begin
        shaped = {SAMPLE_W{phase_acc[PHASE_W-1]}};  // full swing on msb
      end
      WAVE_TRIANGLE: begin
        shaped = phase_acc[PHASE_W-1] ? ~tri_ramp : tri_ramp;  // falling half
      end
      default: begin
        shaped = '0;
      end
    endcase
  end

  // sample lags the accumulator by one cycle
  always_ff @(posedge CLK_25MHZ) begin
    if (reset_from_key) begin
      carrier_sample <= '0;
    end else begin
      carrier_sample <= shaped;
    end
  end

endmodule

`default_nettype wire

//--- rtl/lfsr_modulator.sv
`timescale 1ns/1ps
`default_nettype none

module lfsr_modulator (
  input  wire                       CLK_25MHZ,
  input  wire                       reset_from_key,
  input  wire dds_lab_pkg::sample_t carrier_sample,
  input  wire dds_lab_pkg::lfsr_t   lfsr_state,
  input  wire dds_lab_pkg::mod_sel_e mod_sel,
  output dds_lab_pkg::sample_t      modulated_sample
);

  import dds_lab_pkg::*;

  logic    data_bit;
  sample_t mod_next;

  assign data_bit = lfsr_state[0];  // only the lsb carries data

  //////////////////////////////////////////////////
  // keying of the carrier by the lfsr bit
  //////////////////////////////////////////////////
  always_comb begin
    case (mod_sel)
      MOD_NONE: begin
        mod_next = carrier_sample;
      end
      MOD_ASK: begin
        mod_next = data_bit ? carrier_sample : '0;  // on-off keying
      end
      MOD_BPSK: begin
        mod_next = data_bit ? ~carrier_sample : carrier_sample;  // flip about mid-scale
      end
      default: begin
        mod_next = carrier_sample;
      end
    endcase
  end

  always_ff @(posedge CLK_25MHZ) begin
    if (reset_from_key) begin
      modulated_sample <= '0;
    end else begin
      modulated_sample <= mod_next;
    end
  end

endmodule

`default_nettype wire

//--- rtl/dds_lab_top.sv
`timescale 1ns/1ps
`default_nettype none

module dds_lab_top #(
  parameter int DIV_COUNT = 25000000  // one lfsr step per second at 25 mhz
) (
  input  wire                          CLK_25MHZ,
  input  wire                          reset_from_key,
  input  wire                          key_event_ready,
  input  wire dds_lab_pkg::scan_code_t key_event_code,
  input  wire dds_lab_pkg::phase_t     phase_inc,
  input  wire dds_lab_pkg::wave_sel_e  wave_sel,
  input  wire dds_lab_pkg::mod_sel_e   mod_sel,
  output dds_lab_pkg::held_keys_t      held_keys,
  output dds_lab_pkg::lfsr_t           lfsr_state,
  output dds_lab_pkg::sample_t         carrier_sample,
  output dds_lab_pkg::sample_t         modulated_sample
);

  //////////////////////////////////////////////////
  // keyboard side
  //////////////////////////////////////////////////
  key_hold_tracker u_key_hold_tracker (
    .CLK_25MHZ      (CLK_25MHZ),
    .reset_from_key (reset_from_key),
    .key_event_ready(key_event_ready),
    .key_event_code (key_event_code),
    .held_keys      (held_keys)
  );

  //////////////////////////////////////////////////
  // signal path: lfsr, carrier, modulator
  //////////////////////////////////////////////////
  lfsr_stepper #(
    .DIV_COUNT(DIV_COUNT)
  ) u_lfsr_stepper (
    .CLK_25MHZ     (CLK_25MHZ),
    .reset_from_key(reset_from_key),
    .lfsr_state    (lfsr_state)
  );

  dds_wave_gen u_dds_wave_gen (
    .CLK_25MHZ     (CLK_25MHZ),
    .reset_from_key(reset_from_key),
    .phase_inc     (phase_inc),
    .wave_sel      (wave_sel),
    .carrier_sample(carrier_sample)
  );

  lfsr_modulator u_lfsr_modulator (
    .CLK_25MHZ       (CLK_25MHZ),
    .reset_from_key  (reset_from_key),
    .carrier_sample  (carrier_sample),  // also a top-level output
    .lfsr_state      (lfsr_state),
    .mod_sel         (mod_sel),
    .modulated_sample(modulated_sample)
  );

endmodule

`default_nettype wire

//--- tb/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int RESET_CYCLES = 16
) (
  output logic CLK_25MHZ,
  output logic power_on_reset
);

  initial begin
    CLK_25MHZ = 1'b0;
    forever #20 CLK_25MHZ = ~CLK_25MHZ;  // 40 ns period
  end

  initial begin
    power_on_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK_25MHZ);
    #2;
    power_on_reset = 1'b0;  // released just after an edge
  end

endmodule

`default_nettype wire

//--- tb/dds_lab_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dds_lab_checker #(
  parameter int DIV_COUNT = 10
) (
  input  wire                          CLK_25MHZ,
  input  wire                          reset_from_key,
  input  wire                          key_event_ready,
  input  wire dds_lab_pkg::scan_code_t key_event_code,
  input  wire dds_lab_pkg::phase_t     phase_inc,
  input  wire dds_lab_pkg::wave_sel_e  wave_sel,
  input  wire dds_lab_pkg::mod_sel_e   mod_sel,
  input  wire dds_lab_pkg::held_keys_t held_keys,
  input  wire dds_lab_pkg::lfsr_t      lfsr_state,
  input  wire dds_lab_pkg::sample_t    carrier_sample,
  input  wire dds_lab_pkg::sample_t    modulated_sample,
  input  wire                          test_done,
  input  wire [31:0]                   test_num,
  output int unsigned                  check_count,
  output int unsigned                  error_count
);

  import dds_lab_pkg::*;

  // key 1 first as it owns the msb of held_keys
  localparam scan_code_t KEY_MAKE [17] = '{
    SC_MAKE_1, SC_MAKE_2, SC_MAKE_3, SC_MAKE_4, SC_MAKE_5, SC_MAKE_6,
    SC_MAKE_7, SC_MAKE_8, SC_MAKE_F1, SC_MAKE_F2, SC_MAKE_N, SC_MAKE_M,
    SC_MAKE_SPACE, SC_MAKE_LEFT_ARROW, SC_MAKE_RIGHT_ARROW,
    SC_MAKE_UP_ARROW, SC_MAKE_DOWN_ARROW
  };

  held_keys_t  exp_held;
  lfsr_t       exp_lfsr;
  phase_t      exp_acc;
  sample_t     exp_carrier;
  sample_t     exp_mod;
  int          cycles_since_reset;
  logic        model_valid = 1'b0;  // set by the first reset edge
  int unsigned checks = 0;
  int unsigned errors = 0;
  int unsigned test_errors = 0;

  assign check_count = checks;
  assign error_count = errors;

  function automatic sample_t shape(phase_t acc, wave_sel_e sel);
    case (sel)
      WAVE_SAW:      return acc[31:20];
      WAVE_SQUARE:   return acc[31] ? 12'hFFF : 12'h000;
      WAVE_TRIANGLE: return acc[31] ? ~acc[30:19] : acc[30:19];
      default:       return 12'h000;
    endcase
  endfunction

  function automatic sample_t keyed(sample_t carrier, logic data, mod_sel_e sel);
    case (sel)
      MOD_ASK:  return data ? carrier : 12'h000;
      MOD_BPSK: return data ? ~carrier : carrier;
      default:  return carrier;
    endcase
  endfunction

  function automatic string test_name(int num);
    case (num)
      1:       return "lfsr sequence";
      2:       return "held keys";
      3:       return "saw carrier";
      4:       return "square carrier";
      5:       return "triangle carrier";
      6:       return "modulation";
      default: return "reset in mid-run";
    endcase
  endfunction

  task automatic compare(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("Fail at %0d ns: %s expected %0h got %0h", $time, name, expected, actual);
    end
  endtask

  //////////////////////////////////////////////////
  // compare last edge's results before stepping the model
  //////////////////////////////////////////////////
  always @(posedge CLK_25MHZ) begin
    if (model_valid) begin
      compare("held_keys", exp_held, held_keys);
      compare("lfsr_state", exp_lfsr, lfsr_state);
      compare("carrier_sample", exp_carrier, carrier_sample);
      compare("modulated_sample", exp_mod, modulated_sample);
    end
    if (test_done) begin
      $display("test %0d (%s) finished with %0d errors", test_num, test_name(test_num),
               test_errors);
      test_errors = 0;
    end
    if (reset_from_key) begin
      exp_held           = '0;
      exp_lfsr           = LFSR_SEED;
      exp_acc            = '0;
      exp_carrier        = '0;
      exp_mod            = '0;
      cycles_since_reset = 0;
      model_valid        = 1'b1;
    end else begin
      exp_mod     = keyed(exp_carrier, exp_lfsr[0], mod_sel);  // old carrier and old bit
      exp_carrier = shape(exp_acc, wave_sel);
      exp_acc     = exp_acc + phase_inc;
      if (key_event_ready) begin
        for (int i = 0; i < 17; i++) begin
          if (key_event_code == KEY_MAKE[i]) begin
            exp_held[16 - i] = 1'b1;
          end else if (key_event_code == (KEY_MAKE[i] | 8'h80)) begin
            exp_held[16 - i] = 1'b0;
          end
        end
      end
      cycles_since_reset++;
      if (cycles_since_reset % DIV_COUNT == 0) begin
        exp_lfsr = {exp_lfsr[3:0], exp_lfsr[4] ^ exp_lfsr[2]};
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/dds_lab_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module dds_lab_assertions (
  input wire                     CLK_25MHZ,
  input wire                     reset_from_key,
  input wire dds_lab_pkg::lfsr_t lfsr_state
);

  import dds_lab_pkg::*;

  int unsigned fail_count = 0;

  // an all-zero state would lock up
  never_zero: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
    lfsr_state != '0)
  else begin
    fail_count++;
    $error("lfsr state reached zero");
  end

  seed_in_reset: assert property (@(posedge CLK_25MHZ)
    reset_from_key |=> lfsr_state == LFSR_SEED)
  else begin
    fail_count++;
    $error("lfsr state is not the seed during reset");
  end

  shift_rule: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
    !$past(reset_from_key) && $changed(lfsr_state) |->
      lfsr_state == {$past(lfsr_state[3:0]), $past(lfsr_state[4] ^ lfsr_state[2])})
  else begin
    fail_count++;
    $error("lfsr state changed against the shift rule");
  end

endmodule

bind lfsr_stepper dds_lab_assertions u_lfsr_assertions (
  .CLK_25MHZ     (CLK_25MHZ),
  .reset_from_key(reset_from_key),
  .lfsr_state    (lfsr_state)
);

`default_nettype wire

//--- tb/dds_lab_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dds_lab_tb;

  import dds_lab_pkg::*;

  localparam int DIV_COUNT      = 10;
  localparam int SEED           = 93;
  localparam int KEY_EVENTS     = 300;
  localparam int MAX_GAP        = 3;
  localparam int LFSR_STEPS     = 40;
  localparam int WAVE_CYCLES    = 200;
  localparam int MOD_CYCLES     = 150;
  localparam int RESET_CYCLES   = 16;
  localparam int RERESET_CYCLES = 8;
  localparam int TAIL_CYCLES    = 30;
  localparam int TEST_CYCLES    = RESET_CYCLES + LFSR_STEPS * DIV_COUNT
                                + KEY_EVENTS * (MAX_GAP + 1) + 3 * WAVE_CYCLES
                                + 3 * MOD_CYCLES + RERESET_CYCLES + TAIL_CYCLES + 7 * 2;
  localparam int CYCLE_LIMIT    = TEST_CYCLES * 12 / 10;  // 20 percent margin

  localparam scan_code_t KEY_MAKE [17] = '{
    SC_MAKE_1, SC_MAKE_2, SC_MAKE_3, SC_MAKE_4, SC_MAKE_5, SC_MAKE_6,
    SC_MAKE_7, SC_MAKE_8, SC_MAKE_F1, SC_MAKE_F2, SC_MAKE_N, SC_MAKE_M,
    SC_MAKE_SPACE, SC_MAKE_LEFT_ARROW, SC_MAKE_RIGHT_ARROW,
    SC_MAKE_UP_ARROW, SC_MAKE_DOWN_ARROW
  };

  logic        CLK_25MHZ;
  logic        power_on_reset;
  logic        tb_reset;
  logic        reset_from_key;
  logic        key_event_ready;
  scan_code_t  key_event_code;
  phase_t      phase_inc;
  wave_sel_e   wave_sel;
  mod_sel_e    mod_sel;
  held_keys_t  held_keys;
  lfsr_t       lfsr_state;
  sample_t     carrier_sample;
  sample_t     modulated_sample;
  logic        test_done;
  int          test_num;
  int unsigned check_count;
  int unsigned error_count;
  int          cycle_count = 0;

  assign reset_from_key = power_on_reset | tb_reset;

  clock_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clock_gen (.*);

  dds_lab_top #(.DIV_COUNT(DIV_COUNT)) u_dds_lab_top (.*);

  dds_lab_checker #(.DIV_COUNT(DIV_COUNT)) u_dds_lab_checker (.*);

  task automatic next_cycle();
    @(posedge CLK_25MHZ);
    #2;  // inputs move clear of the edge
  endtask

  task automatic finish_test(int num);
    test_num  = num;
    test_done = 1'b1;
    next_cycle();
    test_done = 1'b0;
  endtask

  task automatic run_wave(wave_sel_e sel, int num);
    wave_sel  = sel;
    phase_inc = $urandom;
    repeat (WAVE_CYCLES) next_cycle();
    finish_test(num);
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin
    int          gap;
    int unsigned total_errors;
    void'($urandom(SEED));
    tb_reset        = 1'b0;
    key_event_ready = 1'b0;
    key_event_code  = '0;
    phase_inc       = '0;
    wave_sel        = WAVE_SAW;
    mod_sel         = MOD_NONE;
    test_done       = 1'b0;
    test_num        = 0;
    @(negedge power_on_reset);
    repeat (LFSR_STEPS * DIV_COUNT) next_cycle();  // lfsr runs from the seed
    finish_test(1);
    for (int n = 0; n < KEY_EVENTS; n++) begin
      gap = $urandom_range(MAX_GAP, 0);
      repeat (gap) begin
        key_event_ready = 1'b0;
        key_event_code  = KEY_MAKE[$urandom_range(16, 0)];  // must be ignored
        next_cycle();
      end
      key_event_ready = 1'b1;
      key_event_code  = KEY_MAKE[$urandom_range(16, 0)] | ($urandom_range(1, 0) ? 8'h80 : 8'h00);
      next_cycle();
    end
    key_event_ready = 1'b0;
    finish_test(2);
    run_wave(WAVE_SAW, 3);
    run_wave(WAVE_SQUARE, 4);
    run_wave(WAVE_TRIANGLE, 5);
    phase_inc = $urandom;
    mod_sel   = MOD_NONE;
    repeat (MOD_CYCLES) next_cycle();
    mod_sel = MOD_ASK;
    repeat (MOD_CYCLES) next_cycle();
    mod_sel = MOD_BPSK;
    repeat (MOD_CYCLES) next_cycle();
    finish_test(6);
    tb_reset = 1'b1;  // second reset while running
    repeat (RERESET_CYCLES) next_cycle();
    tb_reset = 1'b0;
    repeat (TAIL_CYCLES) next_cycle();
    finish_test(7);
    next_cycle();
    total_errors = error_count + u_dds_lab_top.u_lfsr_stepper.u_lfsr_assertions.fail_count;
    $display("%0d checks, %0d errors, %0d assertion failures", check_count, error_count,
             u_dds_lab_top.u_lfsr_stepper.u_lfsr_assertions.fail_count);
    if (total_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // run limit
  always @(posedge CLK_25MHZ) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- filelist.f
rtl/dds_lab_pkg.sv
rtl/key_hold_tracker.sv
rtl/lfsr_stepper.sv
rtl/dds_wave_gen.sv
rtl/lfsr_modulator.sv
rtl/dds_lab_top.sv
tb/clock_gen.sv
tb/dds_lab_checker.sv
tb/dds_lab_assertions.sv
tb/dds_lab_tb.sv
